//--- design/udp_rx_pkg.sv
// Shared widths, field types and constants for the UDP receive block
// Frame state encoding used by the receive FSM

package udp_rx_pkg;

    // Datapath geometry, one UDP header fills exactly one beat
    localparam int DATA_W = 64;
    localparam int KEEP_W = DATA_W / 8;

    // UDP header size in bytes
    localparam int UDP_HDR_BYTES = 8;

    // IP protocol field value for UDP
    localparam logic [7:0] IP_PROTO_UDP = 8'h11;

    // Header field types
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] port_t;
    typedef logic [15:0] len_t;
    typedef logic [7:0]  proto_t;

    // Receive frame states
    typedef enum logic [2:0] {
        // Waiting for an IP header
        ST_IDLE,
        // Expecting the beat that holds the UDP header
        ST_HDR_BEAT,
        // Discarding a non-UDP payload
        ST_DROP,
        // Presenting the UDP header downstream
        ST_HDR_OUT,
        // Forwarding payload beats
        ST_PAYLOAD
    } rx_state_e;

endpackage

//--- design/udp_hdr_if.sv
// Captured IP and UDP header fields shared between the receive modules
// Written by the capture block, read by the length counter and top level

interface udp_hdr_if;

    import udp_rx_pkg::*;

    ip_addr_t source_ip;
    ip_addr_t dest_ip;
    port_t    source_port;
    port_t    dest_port;
    len_t     length;
    port_t    checksum;

    modport capture (
        output source_ip, dest_ip, source_port, dest_port, length, checksum
    );

    modport consumer (
        input source_ip, dest_ip, source_port, dest_port, length, checksum
    );

endinterface

//--- design/udp_hdr_capture.sv
// Header field capture
// Stores the IP addresses and splits the UDP header beat into its fields

module udp_hdr_capture (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic                            ip_hdr_take,
    input  udp_rx_pkg::ip_addr_t            s_ip_source_ip,
    input  udp_rx_pkg::ip_addr_t            s_ip_dest_ip,
    input  logic                            udp_hdr_take,
    input  logic [udp_rx_pkg::DATA_W-1:0]   hdr_beat,
    udp_hdr_if.capture                      hdr
);

    import udp_rx_pkg::*;

    // Byte 0 sits in the low bits of the beat but is the high byte on the wire
    function automatic port_t be16(input logic [15:0] w);
        return {w[7:0], w[15:8]};
    endfunction

    // Held until the next frame overwrites them
    ip_addr_t source_ip_q;
    ip_addr_t dest_ip_q;
    port_t    source_port_q;
    port_t    dest_port_q;
    len_t     length_q;
    port_t    checksum_q;

    always_ff @(posedge clk) begin
        if (ip_hdr_take) begin
            source_ip_q <= s_ip_source_ip;
            dest_ip_q   <= s_ip_dest_ip;
        end
    end

    // Fields at byte pairs 0/1, 2/3, 4/5 and 6/7
    always_ff @(posedge clk) begin
        if (udp_hdr_take) begin
            source_port_q <= be16(hdr_beat[15:0]);
            dest_port_q   <= be16(hdr_beat[31:16]);
            length_q      <= be16(hdr_beat[47:32]);
            checksum_q    <= be16(hdr_beat[63:48]);
        end
    end

    // Field outputs read as zero until the first UDP header arrives
    logic fields_seen_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fields_seen_q <= 1'b0;
        end else if (udp_hdr_take) begin
            fields_seen_q <= 1'b1;
        end
    end

    assign hdr.source_ip   = fields_seen_q ? source_ip_q : '0;
    assign hdr.dest_ip     = fields_seen_q ? dest_ip_q : '0;
    assign hdr.source_port = fields_seen_q ? source_port_q : '0;
    assign hdr.dest_port   = fields_seen_q ? dest_port_q : '0;
    assign hdr.length      = fields_seen_q ? length_q : '0;
    assign hdr.checksum    = fields_seen_q ? checksum_q : '0;

endmodule

//--- design/udp_len_counter.sv
// Payload byte counter
// Tracks the bytes left from the UDP length and flags a mismatch on the last beat

module udp_len_counter (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic                            count_load,
    udp_hdr_if.consumer                     hdr,
    input  logic                            beat_take,
    input  logic [udp_rx_pkg::KEEP_W-1:0]   keep,
    input  logic                            last,
    output logic                            len_error
);

    import udp_rx_pkg::*;

    function automatic len_t count_bytes(input logic [KEEP_W-1:0] k);
        len_t n;
        n = '0;
        for (int i = 0; i < KEEP_W; i++) begin
            n = n + len_t'(k[i]);
        end
        return n;
    endfunction

    len_t remaining_q;
    logic overrun_q;
    len_t beat_bytes;
    len_t load_value;

    assign beat_bytes = count_bytes(keep);

    // Payload bytes only, a length below the header size counts as empty
    assign load_value = (hdr.length > len_t'(UDP_HDR_BYTES)) ?
                        hdr.length - len_t'(UDP_HDR_BYTES) : '0;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            remaining_q <= '0;
            overrun_q   <= 1'b0;
        end else if (count_load) begin
            remaining_q <= load_value;
            overrun_q   <= 1'b0;
        end else if (beat_take) begin
            if (beat_bytes > remaining_q) begin
                // Frame longer than announced, remember it for the last beat
                remaining_q <= '0;
                overrun_q   <= 1'b1;
            end else begin
                remaining_q <= remaining_q - beat_bytes;
            end
        end
    end

    assign len_error = last && (overrun_q || (remaining_q != beat_bytes));

endmodule

//--- design/udp_rx_fsm.sv
// Receive frame FSM
// Steers the header and payload handshakes, drops non-UDP frames, raises errors
// Take and load strobes for the capture and counter blocks

module udp_rx_fsm (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                s_ip_hdr_valid,
    output logic                s_ip_hdr_ready,
    input  udp_rx_pkg::proto_t  s_ip_protocol,
    input  logic                s_payload_tvalid,
    output logic                s_payload_tready,
    input  logic                s_payload_tlast,
    output logic                m_udp_hdr_valid,
    input  logic                m_udp_hdr_ready,
    output logic                m_payload_tvalid,
    input  logic                m_payload_tready,
    output logic                m_payload_tuser,
    output logic                ip_hdr_take,
    output logic                udp_hdr_take,
    output logic                count_load,
    output logic                beat_take,
    input  logic                len_error,
    output logic                busy,
    output logic                error_header_early_termination,
    output logic                error_payload_length
);

    import udp_rx_pkg::*;

    rx_state_e state_q;
    rx_state_e state_d;
    logic      proto_match_q;
    logic      hdr_early_d;
    logic      hdr_early_q;

    always_comb begin
        state_d          = state_q;
        s_ip_hdr_ready   = 1'b0;
        s_payload_tready = 1'b0;
        m_udp_hdr_valid  = 1'b0;
        m_payload_tvalid = 1'b0;
        ip_hdr_take      = 1'b0;
        udp_hdr_take     = 1'b0;
        count_load       = 1'b0;
        beat_take        = 1'b0;
        hdr_early_d      = 1'b0;

        unique case (state_q)
            ST_IDLE: begin
                s_ip_hdr_ready = 1'b1;
                if (s_ip_hdr_valid) begin
                    ip_hdr_take = 1'b1;
                    state_d     = ST_HDR_BEAT;
                end
            end
            ST_HDR_BEAT: begin
                s_payload_tready = 1'b1;
                if (s_payload_tvalid) begin
                    udp_hdr_take = proto_match_q && !s_payload_tlast;
                    if (s_payload_tlast) begin
                        // Frame ended inside the UDP header
                        hdr_early_d = proto_match_q;
                        state_d     = ST_IDLE;
                    end else if (!proto_match_q) begin
                        state_d = ST_DROP;
                    end else begin
                        state_d = ST_HDR_OUT;
                    end
                end
            end
            ST_HDR_OUT: begin
                m_udp_hdr_valid = 1'b1;
                if (m_udp_hdr_ready) begin
                    count_load = 1'b1;
                    state_d    = ST_PAYLOAD;
                end
            end
            ST_PAYLOAD: begin
                // Straight pass-through, output stall holds the input
                m_payload_tvalid = s_payload_tvalid;
                s_payload_tready = m_payload_tready;
                beat_take        = s_payload_tvalid && m_payload_tready;
                if (beat_take && s_payload_tlast) begin
                    state_d = ST_IDLE;
                end
            end
            ST_DROP: begin
                s_payload_tready = 1'b1;
                if (s_payload_tvalid && s_payload_tlast) begin
                    state_d = ST_IDLE;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q       <= ST_IDLE;
            proto_match_q <= 1'b0;
            hdr_early_q   <= 1'b0;
        end else begin
            state_q     <= state_d;
            hdr_early_q <= hdr_early_d;
            if (ip_hdr_take) begin
                proto_match_q <= (s_ip_protocol == IP_PROTO_UDP);
            end
        end
    end

    // tuser stays stable while the last beat waits for ready
    assign m_payload_tuser = (state_q == ST_PAYLOAD) && len_error;

    assign error_payload_length           = beat_take && s_payload_tlast && len_error;
    assign error_header_early_termination = hdr_early_q;
    assign busy                           = (state_q != ST_IDLE);

endmodule

//--- design/udp_rx_64.sv
// UDP receive block, 64-bit datapath
// Connects header capture, payload length counter and frame FSM

module udp_rx_64 (
    input  logic                            clk,
    input  logic                            arst_n,

    // IP header input
    input  logic                            s_ip_hdr_valid,
    output logic                            s_ip_hdr_ready,
    input  udp_rx_pkg::proto_t              s_ip_protocol,
    input  udp_rx_pkg::ip_addr_t            s_ip_source_ip,
    input  udp_rx_pkg::ip_addr_t            s_ip_dest_ip,

    // IP payload input
    input  logic [udp_rx_pkg::DATA_W-1:0]   s_payload_tdata,
    input  logic [udp_rx_pkg::KEEP_W-1:0]   s_payload_tkeep,
    input  logic                            s_payload_tvalid,
    output logic                            s_payload_tready,
    input  logic                            s_payload_tlast,

    // UDP header output
    output logic                            m_udp_hdr_valid,
    input  logic                            m_udp_hdr_ready,
    output udp_rx_pkg::ip_addr_t            m_udp_source_ip,
    output udp_rx_pkg::ip_addr_t            m_udp_dest_ip,
    output udp_rx_pkg::port_t               m_udp_source_port,
    output udp_rx_pkg::port_t               m_udp_dest_port,
    output udp_rx_pkg::len_t                m_udp_length,
    output udp_rx_pkg::port_t               m_udp_checksum,

    // UDP payload output
    output logic [udp_rx_pkg::DATA_W-1:0]   m_payload_tdata,
    output logic [udp_rx_pkg::KEEP_W-1:0]   m_payload_tkeep,
    output logic                            m_payload_tvalid,
    input  logic                            m_payload_tready,
    output logic                            m_payload_tlast,
    output logic                            m_payload_tuser,

    // Status
    output logic                            busy,
    output logic                            error_header_early_termination,
    output logic                            error_payload_length
);

    logic ip_hdr_take;
    logic udp_hdr_take;
    logic count_load;
    logic beat_take;
    logic len_error;

    udp_hdr_if hdr_if ();

    udp_hdr_capture capture_i (
        .clk            (clk),
        .arst_n         (arst_n),
        .ip_hdr_take    (ip_hdr_take),
        .s_ip_source_ip (s_ip_source_ip),
        .s_ip_dest_ip   (s_ip_dest_ip),
        .udp_hdr_take   (udp_hdr_take),
        .hdr_beat       (s_payload_tdata),
        .hdr            (hdr_if.capture)
    );

    udp_len_counter counter_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .count_load (count_load),
        .hdr        (hdr_if.consumer),
        .beat_take  (beat_take),
        .keep       (s_payload_tkeep),
        .last       (s_payload_tlast),
        .len_error  (len_error)
    );

    udp_rx_fsm fsm_i (
        .clk                            (clk),
        .arst_n                         (arst_n),
        .s_ip_hdr_valid                 (s_ip_hdr_valid),
        .s_ip_hdr_ready                 (s_ip_hdr_ready),
        .s_ip_protocol                  (s_ip_protocol),
        .s_payload_tvalid               (s_payload_tvalid),
        .s_payload_tready               (s_payload_tready),
        .s_payload_tlast                (s_payload_tlast),
        .m_udp_hdr_valid                (m_udp_hdr_valid),
        .m_udp_hdr_ready                (m_udp_hdr_ready),
        .m_payload_tvalid               (m_payload_tvalid),
        .m_payload_tready               (m_payload_tready),
        .m_payload_tuser                (m_payload_tuser),
        .ip_hdr_take                    (ip_hdr_take),
        .udp_hdr_take                   (udp_hdr_take),
        .count_load                     (count_load),
        .beat_take                      (beat_take),
        .len_error                      (len_error),
        .busy                           (busy),
        .error_header_early_termination (error_header_early_termination),
        .error_payload_length           (error_payload_length)
    );

    // Header fields onto the output ports
    assign m_udp_source_ip   = hdr_if.source_ip;
    assign m_udp_dest_ip     = hdr_if.dest_ip;
    assign m_udp_source_port = hdr_if.source_port;
    assign m_udp_dest_port   = hdr_if.dest_port;
    assign m_udp_length      = hdr_if.length;
    assign m_udp_checksum    = hdr_if.checksum;

    // Payload passes unchanged, qualified by the FSM valid
    assign m_payload_tdata = s_payload_tdata;
    assign m_payload_tkeep = s_payload_tkeep;
    assign m_payload_tlast = s_payload_tlast;

endmodule

//--- dv/udp_rx_64_assert.sv
// Concurrent checks on the receive block handshakes and status outputs
// Bound into the top level

module udp_rx_64_assert (
    input logic clk,
    input logic arst_n,
    input logic s_payload_tvalid,
    input logic s_payload_tready,
    input logic m_udp_hdr_valid,
    input logic m_udp_hdr_ready,
    input logic m_payload_tvalid,
    input logic m_payload_tready,
    input logic busy,
    input logic error_header_early_termination,
    input logic error_payload_length
);

    timeunit 1ns;
    timeprecision 1ps;

    // Valid holds until the transfer
    s_payload_hold: assert property (@(posedge clk) disable iff (!arst_n)
        s_payload_tvalid && !s_payload_tready |=> s_payload_tvalid)
        else $error("s_payload_tvalid dropped without a transfer");

    m_udp_hdr_hold: assert property (@(posedge clk) disable iff (!arst_n)
        m_udp_hdr_valid && !m_udp_hdr_ready |=> m_udp_hdr_valid)
        else $error("m_udp_hdr_valid dropped without a transfer");

    m_payload_hold: assert property (@(posedge clk) disable iff (!arst_n)
        m_payload_tvalid && !m_payload_tready |=> m_payload_tvalid)
        else $error("m_payload_tvalid dropped without a transfer");

    // Error strobes are single-cycle pulses
    early_pulse: assert property (@(posedge clk) disable iff (!arst_n)
        error_header_early_termination |=> !error_header_early_termination)
        else $error("header error strobe longer than one cycle");

    length_pulse: assert property (@(posedge clk) disable iff (!arst_n)
        error_payload_length |=> !error_payload_length)
        else $error("payload length error strobe longer than one cycle");

    hdr_while_busy: assert property (@(posedge clk) disable iff (!arst_n)
        m_udp_hdr_valid |-> busy)
        else $error("m_udp_hdr_valid high while the block is idle");

endmodule

bind udp_rx_64 udp_rx_64_assert assert_i (
    .clk                            (clk),
    .arst_n                         (arst_n),
    .s_payload_tvalid               (s_payload_tvalid),
    .s_payload_tready               (s_payload_tready),
    .m_udp_hdr_valid                (m_udp_hdr_valid),
    .m_udp_hdr_ready                (m_udp_hdr_ready),
    .m_payload_tvalid               (m_payload_tvalid),
    .m_payload_tready               (m_payload_tready),
    .busy                           (busy),
    .error_header_early_termination (error_header_early_termination),
    .error_payload_length           (error_payload_length)
);

//--- dv/udp_rx_64_tb.sv
// Directed testbench for the 64-bit UDP receive block
// Clock, reset, frame driver, output monitor, compare tasks and watchdog

module udp_rx_64_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import udp_rx_pkg::*;

    localparam int CLK_PERIOD  = 40;
    // Header beats plus payload beats over all tests
    localparam int TOTAL_BEATS = 40;
    localparam int WATCHDOG_NS = (TOTAL_BEATS + 200) * CLK_PERIOD * 4;
    localparam int IDLE_LIMIT  = 16;

    typedef struct packed {
        ip_addr_t sip;
        ip_addr_t dip;
        port_t    sport;
        port_t    dport;
        len_t     len;
        port_t    csum;
    } hdr_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [KEEP_W-1:0] keep;
        logic              last;
        logic              user;
    } beat_t;

    logic              clk;
    logic              arst_n;
    logic              s_ip_hdr_valid;
    logic              s_ip_hdr_ready;
    proto_t            s_ip_protocol;
    ip_addr_t          s_ip_source_ip;
    ip_addr_t          s_ip_dest_ip;
    logic [DATA_W-1:0] s_payload_tdata;
    logic [KEEP_W-1:0] s_payload_tkeep;
    logic              s_payload_tvalid;
    logic              s_payload_tready;
    logic              s_payload_tlast;
    logic              m_udp_hdr_valid;
    logic              m_udp_hdr_ready;
    ip_addr_t          m_udp_source_ip;
    ip_addr_t          m_udp_dest_ip;
    port_t             m_udp_source_port;
    port_t             m_udp_dest_port;
    len_t              m_udp_length;
    port_t             m_udp_checksum;
    logic [DATA_W-1:0] m_payload_tdata;
    logic [KEEP_W-1:0] m_payload_tkeep;
    logic              m_payload_tvalid;
    logic              m_payload_tready;
    logic              m_payload_tlast;
    logic              m_payload_tuser;
    logic              busy;
    logic              error_header_early_termination;
    logic              error_payload_length;

    integer seed = 32'ha3a8_ab69;
    bit     stall_en;
    int     errors;
    int     other_errors;
    int     len_err_count;
    int     early_err_count;
    hdr_t   exp_hdr_q [$];
    hdr_t   got_hdr_q [$];
    beat_t  exp_beat_q [$];
    beat_t  got_beat_q [$];

    udp_rx_64 dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Output ready, random when stalls are enabled
    initial begin
        bit hdr_go;
        bit pay_go;
        m_udp_hdr_ready  = 1'b1;
        m_payload_tready = 1'b1;
        forever begin
            // Drawn on the rising edge, applied on the falling edge
            @(posedge clk);
            hdr_go = stall_en ? (($random(seed) % 3) != 0) : 1'b1;
            pay_go = stall_en ? (($random(seed) % 3) != 0) : 1'b1;
            @(negedge clk);
            m_udp_hdr_ready  = hdr_go;
            m_payload_tready = pay_go;
        end
    end

    // Monitor
    always @(posedge clk) begin
        if (arst_n) begin
            if (m_udp_hdr_valid && m_udp_hdr_ready) begin
                got_hdr_q.push_back({m_udp_source_ip, m_udp_dest_ip, m_udp_source_port,
                                     m_udp_dest_port, m_udp_length, m_udp_checksum});
            end
            if (m_payload_tvalid && m_payload_tready) begin
                got_beat_q.push_back({m_payload_tdata, m_payload_tkeep,
                                      m_payload_tlast, m_payload_tuser});
            end
            if (s_payload_tvalid && s_payload_tready) begin
                compare_bit("busy on input beat", 1'b1, busy);
            end
            if (error_payload_length) begin
                len_err_count++;
                compare_bit("length error on last beat", 1'b1,
                            m_payload_tvalid && m_payload_tready && m_payload_tlast);
            end
            if (error_header_early_termination) begin
                early_err_count++;
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the tests finished");
        $display("Test failed");
        $finish;
    end

    task automatic compare_port(input string name, input port_t exp, input port_t act);
        if (exp !== act) begin
            errors++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic compare_ip(input string name, input ip_addr_t exp, input ip_addr_t act);
        if (exp !== act) begin
            errors++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic compare_len(input string name, input len_t exp, input len_t act);
        if (exp !== act) begin
            errors++;
            $display("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic compare_data(input string name, input logic [DATA_W-1:0] exp,
                                input logic [DATA_W-1:0] act);
        if (exp !== act) begin
            errors++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic compare_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            errors++;
            $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    function automatic hdr_t make_hdr(input port_t sport, input port_t dport, input len_t len);
        hdr_t h;
        h.sip   = {16'hc0a8, sport};
        h.dip   = {16'h0a00, dport};
        h.sport = sport;
        h.dport = dport;
        h.len   = len;
        h.csum  = ~sport;
        return h;
    endfunction

    task automatic put_beat(input logic [DATA_W-1:0] data, input logic [KEEP_W-1:0] keep,
                            input logic last);
        @(negedge clk);
        s_ip_hdr_valid   = 1'b0;
        s_payload_tvalid = 1'b1;
        s_payload_tdata  = data;
        s_payload_tkeep  = keep;
        s_payload_tlast  = last;
        @(posedge clk);
        while (!s_payload_tready) begin
            @(posedge clk);
        end
    endtask

    // One IP header, the UDP header beat, then n_payload beats
    task automatic send_frame(input proto_t proto, input hdr_t h, input int n_payload,
                              input logic [KEEP_W-1:0] last_keep);
        logic [DATA_W-1:0] hdr_beat;
        logic [7:0]        hdr_bytes [UDP_HDR_BYTES];
        beat_t             beats [$];
        beat_t             b;
        int                total;
        hdr_bytes = '{h.sport[15:8], h.sport[7:0], h.dport[15:8], h.dport[7:0],
                      h.len[15:8], h.len[7:0], h.csum[15:8], h.csum[7:0]};
        for (int i = 0; i < UDP_HDR_BYTES; i++) begin
            hdr_beat[8*i +: 8] = hdr_bytes[i];
        end
        total = 0;
        for (int i = 0; i < n_payload; i++) begin
            b.data = {$random(seed), $random(seed)};
            b.keep = (i == n_payload - 1) ? last_keep : '1;
            b.last = (i == n_payload - 1);
            b.user = 1'b0;
            total += $countones(b.keep);
            beats.push_back(b);
        end
        if (proto == IP_PROTO_UDP && n_payload > 0) begin
            // Header and payload bytes must add up to the UDP length
            beats[n_payload-1].user = (total + UDP_HDR_BYTES != int'(h.len));
            exp_hdr_q.push_back(h);
            foreach (beats[i]) begin
                exp_beat_q.push_back(beats[i]);
            end
        end
        @(negedge clk);
        s_ip_hdr_valid = 1'b1;
        s_ip_protocol  = proto;
        s_ip_source_ip = h.sip;
        s_ip_dest_ip   = h.dip;
        @(posedge clk);
        while (!s_ip_hdr_ready) begin
            @(posedge clk);
        end
        put_beat(hdr_beat, '1, n_payload == 0);
        foreach (beats[i]) begin
            put_beat(beats[i].data, beats[i].keep, beats[i].last);
        end
        @(negedge clk);
        s_payload_tvalid = 1'b0;
    endtask

    // Wait for idle, plus one cycle for the registered header error
    task automatic finish_frame(input string name);
        int n;
        n = 0;
        @(negedge clk);
        while (busy && n < IDLE_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (busy) begin
            other_errors++;
            $display("%s: DUT still busy %0d cycles after the frame ended", name, IDLE_LIMIT);
        end
        @(negedge clk);
    endtask

    task automatic check_results(input string name, input int exp_len_err,
                                 input int exp_early_err);
        hdr_t  eh;
        hdr_t  gh;
        beat_t eb;
        beat_t gb;
        compare_len({name, " header count"}, len_t'(exp_hdr_q.size()), len_t'(got_hdr_q.size()));
        compare_len({name, " beat count"}, len_t'(exp_beat_q.size()), len_t'(got_beat_q.size()));
        while (exp_hdr_q.size() > 0 && got_hdr_q.size() > 0) begin
            eh = exp_hdr_q.pop_front();
            gh = got_hdr_q.pop_front();
            compare_ip({name, " source ip"}, eh.sip, gh.sip);
            compare_ip({name, " dest ip"}, eh.dip, gh.dip);
            compare_port({name, " source port"}, eh.sport, gh.sport);
            compare_port({name, " dest port"}, eh.dport, gh.dport);
            compare_len({name, " udp length"}, eh.len, gh.len);
            compare_port({name, " checksum"}, eh.csum, gh.csum);
        end
        while (exp_beat_q.size() > 0 && got_beat_q.size() > 0) begin
            eb = exp_beat_q.pop_front();
            gb = got_beat_q.pop_front();
            compare_data({name, " tdata"}, eb.data, gb.data);
            compare_data({name, " tkeep"}, {{(DATA_W-KEEP_W){1'b0}}, eb.keep},
                         {{(DATA_W-KEEP_W){1'b0}}, gb.keep});
            compare_bit({name, " tlast"}, eb.last, gb.last);
            compare_bit({name, " tuser"}, eb.user, gb.user);
        end
        compare_len({name, " length errors"}, len_t'(exp_len_err), len_t'(len_err_count));
        compare_len({name, " early errors"}, len_t'(exp_early_err), len_t'(early_err_count));
        exp_hdr_q.delete();
        got_hdr_q.delete();
        exp_beat_q.delete();
        got_beat_q.delete();
        len_err_count   = 0;
        early_err_count = 0;
    endtask

    task automatic test_good_frame();
        send_frame(IP_PROTO_UDP, make_hdr(16'h1234, 16'h0050, 16'd36), 4, 8'h0f);
        finish_frame("good_frame");
        check_results("good_frame", 0, 0);
    endtask

    task automatic test_drop_non_udp();
        send_frame(8'd6, make_hdr(16'h0400, 16'h0017, 16'd32), 3, 8'hff);
        finish_frame("drop_non_udp");
        send_frame(IP_PROTO_UDP, make_hdr(16'h2000, 16'h0035, 16'd24), 2, 8'hff);
        finish_frame("drop_non_udp");
        check_results("drop_non_udp", 0, 0);
    endtask

    task automatic test_length_error();
        // 16 payload bytes against 20 announced
        send_frame(IP_PROTO_UDP, make_hdr(16'h3001, 16'h0044, 16'd28), 2, 8'hff);
        finish_frame("short_payload");
        check_results("short_payload", 1, 0);
        // 19 payload bytes against 10 announced
        send_frame(IP_PROTO_UDP, make_hdr(16'h3002, 16'h0045, 16'd18), 3, 8'h07);
        finish_frame("long_payload");
        check_results("long_payload", 1, 0);
    endtask

    task automatic test_early_term();
        send_frame(IP_PROTO_UDP, make_hdr(16'h4000, 16'h0099, 16'd16), 0, 8'hff);
        finish_frame("early_termination");
        send_frame(IP_PROTO_UDP, make_hdr(16'h4001, 16'h009a, 16'd14), 1, 8'h3f);
        finish_frame("early_termination");
        check_results("early_termination", 0, 1);
    endtask

    task automatic test_stalls();
        int n_beats [4] = '{3, 5, 2, 4};
        logic [KEEP_W-1:0] keep;
        int len;
        stall_en = 1'b1;
        for (int f = 0; f < 4; f++) begin
            keep = 8'hff >> f;
            len  = UDP_HDR_BYTES + (n_beats[f] - 1) * 8 + (8 - f);
            send_frame(IP_PROTO_UDP, make_hdr(port_t'(16'h5000 + f), 16'h1f90, len_t'(len)),
                       n_beats[f], keep);
        end
        finish_frame("random_stalls");
        stall_en = 1'b0;
        check_results("random_stalls", 0, 0);
    endtask

    initial begin
        arst_n           = 1'b0;
        stall_en         = 1'b0;
        s_ip_hdr_valid   = 1'b0;
        s_ip_protocol    = '0;
        s_ip_source_ip   = '0;
        s_ip_dest_ip     = '0;
        s_payload_tdata  = '0;
        s_payload_tkeep  = '0;
        s_payload_tvalid = 1'b0;
        s_payload_tlast  = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        test_good_frame();
        test_drop_non_udp();
        test_length_error();
        test_early_term();
        test_stalls();
        $display("Errors: %0d value mismatches, %0d other failures", errors, other_errors);
        if (errors == 0 && other_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- list.f
design/udp_rx_pkg.sv
design/udp_hdr_if.sv
design/udp_hdr_capture.sv
design/udp_len_counter.sv
design/udp_rx_fsm.sv
design/udp_rx_64.sv
dv/udp_rx_64_assert.sv
dv/udp_rx_64_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build the UDP receive testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps \
        -f list.f --top-module udp_rx_64_tb \
    && ./obj_dir/Vudp_rx_64_tb | tee /dev/stderr | grep -q "^Test passed$" \
    && echo "Simulation finished: PASS" \
    || { echo "Simulation finished: FAIL"; exit 1; }
